//--- hw/bridge_cfg.svh
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Response path sizing

// Response buffer depth, also the largest data count per frame
`define BRIDGE_MAX_DATA 64

// TX FIFO depth, power of two so the pointers wrap on their own
`define BRIDGE_FIFO_DEPTH 8

// Protocol constants

// Start of frame, device to host direction
`define BRIDGE_SOF 8'h5A

// CRC-8 polynomial x^8 + x^2 + x + 1, initial value zero
`define BRIDGE_CRC_POLY 8'h07

`endif

//--- hw/bridge_pkg.sv
package bridge_pkg;

    typedef logic [7:0]  byte_t;   // Any byte on a byte path
    typedef logic [31:0] addr_t;   // Echoed AXI address
    typedef logic [6:0]  count_t;  // Data byte count, 0 to 64
    typedef logic [5:0]  index_t;  // Response buffer index

    // Status byte for a clean transaction
    localparam byte_t STATUS_OK = 8'h00;

    // Sequencer states in protocol order
    typedef enum logic [3:0] {
        IDLE,    // Waiting for a request
        SOF,     // Start of frame
        STATUS,  // Status byte
        CMD,     // Command echo
        ADDR0,   // Address bits 7:0
        ADDR1,   // Address bits 15:8
        ADDR2,   // Address bits 23:16
        ADDR3,   // Address bits 31:24
        DATA,    // Read data bytes
        CRC,     // Trailing CRC
        GAP      // One cycle of completion
    } seq_state_t;

endpackage

//--- hw/crc8_accum.sv
`include "bridge_cfg.svh"

module crc8_accum (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,  // Start a new frame
    input  logic              en,     // Fold data in this cycle
    input  bridge_pkg::byte_t data,
    output bridge_pkg::byte_t crc     // Value over all bytes enabled so far
);

    import bridge_pkg::*;

    localparam byte_t POLY = `BRIDGE_CRC_POLY;

    byte_t stage [0:8];  // Partial remainder after each bit
    byte_t crc_q;

    // Byte enters at the top, processed MSB first
    assign stage[0] = crc_q ^ data;

    // One shift and conditional XOR per bit
    for (genvar i = 0; i < 8; i++) begin : g_step
        assign stage[i+1] = stage[i][7] ? ((stage[i] << 1) ^ POLY)
                                        : (stage[i] << 1);
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc_q <= '0;        // Initial value is zero
        end else if (en) begin
            crc_q <= stage[8];  // Remainder after the eighth bit
        end
    end

    assign crc = crc_q;

endmodule

//--- hw/resp_data_buf.sv
`include "bridge_cfg.svh"

module resp_data_buf (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_valid,
    input  bridge_pkg::byte_t  wr_byte,
    output logic               wr_ready,
    input  logic               lock,     // Sequencer busy, no loading
    input  logic               clear,    // Frame done, rewind pointer
    input  bridge_pkg::index_t rd_idx,
    output bridge_pkg::byte_t  rd_byte
);

    import bridge_pkg::*;

    byte_t  mem [0:`BRIDGE_MAX_DATA-1];
    count_t wr_ptr;  // Next free slot, equals bytes stored
    logic   full;
    logic   wr_fire;

    assign full     = (wr_ptr == count_t'(`BRIDGE_MAX_DATA));
    assign wr_ready = !lock && !full;
    assign wr_fire  = wr_valid && wr_ready;

    // Write pointer
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
        end else if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[index_t'(wr_ptr)] <= wr_byte;  // Pointer below 64 when not full
        end
    end

    // Indexed read, combinational for the DATA state
    assign rd_byte = mem[rd_idx];

endmodule

//--- hw/tx_byte_fifo.sv
`include "bridge_cfg.svh"

module tx_byte_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  bridge_pkg::byte_t wr_data,
    output logic              full,
    output logic              rd_valid,  // Head byte present
    output bridge_pkg::byte_t rd_data,
    input  logic              rd_ready
);

    import bridge_pkg::*;

    localparam int DEPTH = `BRIDGE_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    byte_t         mem [0:DEPTH-1];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;   // One extra bit to hold DEPTH
    logic          do_wr;
    logic          do_rd;

    assign full     = (count == (AW + 1)'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];  // Head of queue

    assign do_wr = wr_en && !full;        // Overflow guard
    assign do_rd = rd_valid && rd_ready;  // Stream handshake

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- hw/frame_sequencer.sv
`include "bridge_cfg.svh"

module frame_sequencer (
    input  logic               clk,
    input  logic               rst,

    // Response request
    input  logic               req_valid,
    output logic               req_ready,
    input  bridge_pkg::byte_t  req_status,
    input  bridge_pkg::byte_t  req_cmd,
    input  bridge_pkg::addr_t  req_addr,
    input  bridge_pkg::count_t req_count,

    // TX FIFO write side
    output logic               fifo_wr_en,
    output bridge_pkg::byte_t  fifo_wr_data,
    input  logic               fifo_full,

    // Response buffer
    output bridge_pkg::index_t buf_rd_idx,
    input  bridge_pkg::byte_t  buf_rd_byte,
    output logic               buf_lock,
    output logic               buf_clear,

    // CRC accumulator
    output logic               crc_clear,
    output logic               crc_en,
    output bridge_pkg::byte_t  crc_byte,
    input  bridge_pkg::byte_t  crc_value,

    // Status
    output logic               busy,
    output logic               frame_done
);

    import bridge_pkg::*;

    localparam byte_t SOF_BYTE = `BRIDGE_SOF;

    seq_state_t state;
    seq_state_t state_next;

    // Request fields, captured on acceptance
    byte_t  status_r;
    byte_t  cmd_r;
    addr_t  addr_r;
    count_t count_r;

    count_t data_idx;   // Next data byte to send
    logic   req_fire;
    logic   read_ok;    // Read command that completed cleanly
    logic   last_data;
    logic   in_crc_span;

    assign req_ready = (state == IDLE);
    assign req_fire  = req_valid && req_ready;

    assign read_ok   = cmd_r[7] && (status_r == STATUS_OK);
    assign last_data = (count_t'(data_idx + 1'b1) == count_r);

    // Buffer index from the low bits, count never exceeds 64
    assign buf_rd_idx = index_t'(data_idx);

    // State register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request capture
    always_ff @(posedge clk) begin
        if (req_fire) begin
            status_r <= req_status;
            cmd_r    <= req_cmd;
            addr_r   <= req_addr;
            count_r  <= req_count;
        end
    end

    // Data index steps with each data byte accepted by the FIFO
    always_ff @(posedge clk) begin
        if (rst || req_fire) begin
            data_idx <= '0;
        end else if ((state == DATA) && fifo_wr_en) begin
            data_idx <= data_idx + 1'b1;
        end
    end

    // Next state and byte selection
    always_comb begin
        state_next   = state;
        fifo_wr_en   = 1'b0;
        fifo_wr_data = '0;

        case (state)
            IDLE: begin
                if (req_fire) state_next = SOF;
            end
            SOF: begin
                fifo_wr_data = SOF_BYTE;
                if (!fifo_full) state_next = STATUS;
            end
            STATUS: begin
                fifo_wr_data = status_r;
                if (!fifo_full) state_next = CMD;
            end
            CMD: begin
                fifo_wr_data = cmd_r;
                if (!fifo_full) begin
                    state_next = read_ok ? ADDR0 : CRC;  // Writes and errors end here
                end
            end
            ADDR0: begin
                fifo_wr_data = addr_r[7:0];  // LSB first
                if (!fifo_full) state_next = ADDR1;
            end
            ADDR1: begin
                fifo_wr_data = addr_r[15:8];
                if (!fifo_full) state_next = ADDR2;
            end
            ADDR2: begin
                fifo_wr_data = addr_r[23:16];
                if (!fifo_full) state_next = ADDR3;
            end
            ADDR3: begin
                fifo_wr_data = addr_r[31:24];
                if (!fifo_full) begin
                    state_next = (count_r != '0) ? DATA : CRC;  // Empty read skips DATA
                end
            end
            DATA: begin
                fifo_wr_data = buf_rd_byte;
                if (!fifo_full && last_data) state_next = CRC;
            end
            CRC: begin
                fifo_wr_data = crc_value;  // Covers STATUS up to the last byte
                if (!fifo_full) state_next = GAP;
            end
            GAP: begin
                state_next = IDLE;  // Single completion cycle
            end
            default: begin
                state_next = IDLE;
            end
        endcase

        // Every byte state writes as soon as there is room
        if ((state != IDLE) && (state != GAP) && !fifo_full) begin
            fifo_wr_en = 1'b1;
        end
    end

    // CRC sees everything between SOF and the CRC byte itself
    assign in_crc_span = (state != IDLE) && (state != SOF) &&
                         (state != CRC)  && (state != GAP);
    assign crc_en    = fifo_wr_en && in_crc_span;
    assign crc_byte  = fifo_wr_data;
    assign crc_clear = (state == IDLE);

    assign busy       = (state != IDLE);
    assign buf_lock   = busy;            // No loading mid-frame
    assign frame_done = (state == GAP);
    assign buf_clear  = (state == GAP);  // Next frame loads from index 0

endmodule

//--- hw/resp_frame_tx.sv
module resp_frame_tx (
    input  logic               clk,
    input  logic               rst,

    // Read data loading
    input  logic               data_valid,
    input  bridge_pkg::byte_t  data_byte,
    output logic               data_ready,

    // Response request
    input  logic               req_valid,
    output logic               req_ready,
    input  bridge_pkg::byte_t  req_status,
    input  bridge_pkg::byte_t  req_cmd,
    input  bridge_pkg::addr_t  req_addr,
    input  bridge_pkg::count_t req_count,

    // Byte stream to the UART transmitter
    output logic               tx_valid,
    output bridge_pkg::byte_t  tx_data,
    input  logic               tx_ready,

    output logic               busy,
    output logic               frame_done
);

    import bridge_pkg::*;

    // Sequencer to FIFO
    logic   fifo_wr_en;
    byte_t  fifo_wr_data;
    logic   fifo_full;

    // Sequencer to buffer
    index_t buf_rd_idx;
    byte_t  buf_rd_byte;
    logic   buf_lock;
    logic   buf_clear;

    // Sequencer to CRC
    logic   crc_clear;
    logic   crc_en;
    byte_t  crc_byte;
    byte_t  crc_value;

    frame_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_status   (req_status),
        .req_cmd      (req_cmd),
        .req_addr     (req_addr),
        .req_count    (req_count),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .fifo_full    (fifo_full),
        .buf_rd_idx   (buf_rd_idx),
        .buf_rd_byte  (buf_rd_byte),
        .buf_lock     (buf_lock),
        .buf_clear    (buf_clear),
        .crc_clear    (crc_clear),
        .crc_en       (crc_en),
        .crc_byte     (crc_byte),
        .crc_value    (crc_value),
        .busy         (busy),
        .frame_done   (frame_done)
    );

    crc8_accum u_crc (
        .clk   (clk),
        .rst   (rst),
        .clear (crc_clear),
        .en    (crc_en),
        .data  (crc_byte),
        .crc   (crc_value)
    );

    resp_data_buf u_buf (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (data_valid),
        .wr_byte  (data_byte),
        .wr_ready (data_ready),  // High only while the sequencer is idle
        .lock     (buf_lock),
        .clear    (buf_clear),
        .rd_idx   (buf_rd_idx),
        .rd_byte  (buf_rd_byte)
    );

    tx_byte_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (fifo_wr_en),
        .wr_data  (fifo_wr_data),
        .full     (fifo_full),
        .rd_valid (tx_valid),
        .rd_data  (tx_data),
        .rd_ready (tx_ready)
    );

endmodule

//--- bench/resp_frame_tb.sv
module resp_frame_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import bridge_pkg::*;

    localparam int    MAX_CASES  = 32;
    localparam int    CASE_WORDS = 7;      // status cmd addr count base stall crc
    localparam byte_t SOF_BYTE   = 8'h5A;  // Device to host start of frame
    localparam byte_t CRC_POLY   = 8'h07;

    logic   clk = 1'b0;
    logic   rst;
    logic   data_valid;
    byte_t  data_byte;
    logic   data_ready;
    logic   req_valid;
    logic   req_ready;
    byte_t  req_status;
    byte_t  req_cmd;
    addr_t  req_addr;
    count_t req_count;
    logic   tx_valid;
    byte_t  tx_data;
    logic   tx_ready;
    logic   busy;
    logic   frame_done;

    logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1];
    int          num_cases;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;  // Armed once the cases are read
    byte_t       exp_q [$];        // Expected bytes of the current frame

    resp_frame_tx dut0 (
        .clk        (clk),
        .rst        (rst),
        .data_valid (data_valid),
        .data_byte  (data_byte),
        .data_ready (data_ready),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_status (req_status),
        .req_cmd    (req_cmd),
        .req_addr   (req_addr),
        .req_count  (req_count),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready),
        .busy       (busy),
        .frame_done (frame_done)
    );

    always #2 clk = ~clk;  // 4 ns period

    // Run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout, no end of test after %0d cycles",
                                        cycle_count));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                                        name, got, exp));
        end
    endtask

    // CRC-8 shifted MSB first without reflection
    function automatic byte_t crc8_next(byte_t crc_in, byte_t b);
        byte_t r;
        r = crc_in ^ b;
        for (int k = 0; k < 8; k++) begin
            r = r[7] ? ((r << 1) ^ CRC_POLY) : (r << 1);
        end
        return r;
    endfunction

    function automatic int frame_len(byte_t status, byte_t cmd, int count);
        if (cmd[7] && status == STATUS_OK) begin
            return 8 + count;  // Header, four address bytes, data, CRC
        end
        return 4;              // Write or error frame
    endfunction

    // Fills exp_q with the frame and returns its CRC
    function automatic byte_t build_expected(byte_t status, byte_t cmd, addr_t addr,
                                             int count, byte_t base);
        byte_t crc;
        byte_t b;
        crc = 8'h00;
        exp_q.delete();
        exp_q.push_back(SOF_BYTE);           // Not covered by the CRC
        exp_q.push_back(status);
        crc = crc8_next(crc, status);
        exp_q.push_back(cmd);
        crc = crc8_next(crc, cmd);
        if (cmd[7] && status == STATUS_OK) begin
            for (int k = 0; k < 4; k++) begin
                b = addr[8*k +: 8];          // LSB first
                exp_q.push_back(b);
                crc = crc8_next(crc, b);
            end
            for (int k = 0; k < count; k++) begin
                b = byte_t'(base + k);       // Wraps at 256
                exp_q.push_back(b);
                crc = crc8_next(crc, b);
            end
        end
        exp_q.push_back(crc);
        return crc;
    endfunction

    initial begin
        byte_t       st;
        byte_t       cmd;
        addr_t       addr;
        int          count;
        byte_t       base;
        logic        stall_on;
        byte_t       file_crc;
        byte_t       model_crc;
        int          got;
        int          done_cnt;
        int unsigned limit;

        void'($urandom(94));
        rst        <= 1'b1;
        data_valid <= 1'b0;
        data_byte  <= '0;
        req_valid  <= 1'b0;
        req_status <= '0;
        req_cmd    <= '0;
        req_addr   <= '0;
        req_count  <= '0;
        tx_ready   <= 1'b1;

        // Unused slots stay all ones and mark the end of the list
        for (int i = 0; i < MAX_CASES*CASE_WORDS; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("bench/frame_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*CASE_WORDS] != 32'hFFFF_FFFF) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            stop_with_failure("No cases could be read from bench/frame_cases.txt");
        end
        limit = 100;
        for (int c = 0; c < num_cases; c++) begin
            limit += frame_len(byte_t'(case_mem[c*CASE_WORDS]),
                               byte_t'(case_mem[c*CASE_WORDS + 1]),
                               int'(case_mem[c*CASE_WORDS + 3])) * 8 + 20;
        end
        cycle_limit = limit;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare_value("tx_valid after reset", 32'(tx_valid), 32'd0);   // Nothing queued yet
        compare_value("req_ready after reset", 32'(req_ready), 32'd1);
        compare_value("data_ready after reset", 32'(data_ready), 32'd1);
        compare_value("busy after reset", 32'(busy), 32'd0);
        compare_value("frame_done after reset", 32'(frame_done), 32'd0);

        for (int c = 0; c < num_cases; c++) begin
            st        = byte_t'(case_mem[c*CASE_WORDS + 0]);
            cmd       = byte_t'(case_mem[c*CASE_WORDS + 1]);
            addr      = case_mem[c*CASE_WORDS + 2];
            count     = int'(case_mem[c*CASE_WORDS + 3]);
            base      = byte_t'(case_mem[c*CASE_WORDS + 4]);
            stall_on  = case_mem[c*CASE_WORDS + 5][0];
            file_crc  = byte_t'(case_mem[c*CASE_WORDS + 6]);
            model_crc = build_expected(st, cmd, addr, count, base);
            compare_value("model crc vs cases file", 32'(model_crc), 32'(file_crc));

            // Load the read data one byte per cycle while idle
            for (int i = 0; i < count; i++) begin
                data_valid <= 1'b1;
                data_byte  <= byte_t'(base + i);
                @(posedge clk);
                compare_value("data_ready", 32'(data_ready), 32'd1);
            end
            data_valid <= 1'b0;

            req_valid  <= 1'b1;
            req_status <= st;
            req_cmd    <= cmd;
            req_addr   <= addr;
            req_count  <= count_t'(count);
            @(posedge clk);
            while (!req_ready) @(posedge clk);  // Held until the handshake
            req_valid <= 1'b0;

            // Collect the stream with random back-pressure on stall cases
            got      = 0;
            done_cnt = 0;
            while (got < exp_q.size()) begin
                @(posedge clk);
                if (done_cnt == 0) begin
                    // Frame still in progress, request and loading sides closed
                    compare_value("busy during frame", 32'(busy), 32'd1);
                    compare_value("req_ready during frame", 32'(req_ready), 32'd0);
                    compare_value("data_ready during frame", 32'(data_ready), 32'd0);
                end
                if (frame_done) done_cnt++;
                if (tx_valid && tx_ready) begin
                    compare_value($sformatf("tx_data case %0d byte %0d", c, got),
                                  32'(tx_data), 32'(exp_q[got]));
                    got++;
                end
                tx_ready <= (stall_on && ($urandom % 2 == 0)) ? 1'b0 : 1'b1;
            end
            tx_ready <= 1'b1;

            // Wait for IDLE and one more cycle to catch stray bytes or pulses
            while (!req_ready) begin
                @(posedge clk);
                if (frame_done) done_cnt++;
            end
            @(posedge clk);
            if (frame_done) done_cnt++;
            if (done_cnt == 0) begin
                stop_with_failure($sformatf("frame_done never pulsed for case %0d", c));
            end
            compare_value("frame_done pulse count", 32'(done_cnt), 32'd1);
            compare_value("tx_valid after frame", 32'(tx_valid), 32'd0);  // No extra byte
            compare_value("req_ready after frame", 32'(req_ready), 32'd1);
            compare_value("data_ready after frame", 32'(data_ready), 32'd1);
            compare_value("busy after frame", 32'(busy), 32'd0);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- bench/frame_cases.txt
// Response frame cases, one case per line, every field in hex
// status  cmd  addr  count  base  stall  crc
// count is the number of data bytes loaded, data byte i is base + i mod 256
// stall 1 drives tx_ready randomly low during the frame
// crc is the CRC-8 over every byte between SOF and the CRC byte

// Write with OK status, frame is SOF STATUS CMD CRC
00 01 20000004 00 00 0 07

// Read with OK status and no data, address bytes only
00 80 12345678 00 00 0 9F

// Read with OK status and one data byte
00 81 000000FC 01 A5 0 28

// Read with an error status, data is loaded but not sent
03 80 40000020 04 10 0 B6

// Short read right after the error frame, data wraps past FF
// The first byte has to come from index 0 again
00 82 00000001 03 FE 1 D1

// Write with an error status under back-pressure
02 02 0000ABCD 00 00 1 24

// Full buffer read, 64 data bytes
00 80 00000000 40 00 0 C1

// Same full read under back-pressure, same bytes expected
00 80 00000000 40 00 1 C1

// Write with OK status under back-pressure
00 01 80001000 00 00 1 07

//--- filelist.f
+incdir+hw
hw/bridge_pkg.sv
hw/crc8_accum.sv
hw/resp_data_buf.sv
hw/tx_byte_fifo.sv
hw/frame_sequencer.sv
hw/resp_frame_tx.sv
bench/resp_frame_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the response frame testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
    --top-module resp_frame_tb -o resp_frame_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Build failed"; exit 1; }

./obj_dir/resp_frame_sim >> sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL, no result in log"; exit 1; }
echo "PASS"
